/* all.f */
+incdir+rtl
rtl/mb_geom_pkg.sv
rtl/pixel_pkg.sv
rtl/line_buffer_ram.sv
rtl/wb_arbiter.sv
rtl/boundary_writer.sv
rtl/neighbor_fetch.sv
rtl/intra_boundary_top.sv
tb/clk_rst_gen.sv
tb/intra_boundary_tb.sv

/* rtl/boundary_writer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "intra_config.svh"

module boundary_writer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   store_valid,
    output logic                   store_ready,
    input  pixel_pkg::mb_edges_t   store_edges,
    input  mb_geom_pkg::mb_coord_t store_col,
    output pixel_pkg::mb_edges_t   left_edges,
    output pixel_pkg::wb_m2s_t     bus_out,
    input  pixel_pkg::wb_s2m_t     bus_in
);
    import mb_geom_pkg::*;
    import pixel_pkg::*;

    typedef enum logic [1:0] {
        idle,
        wr_luma,
        wr_chroma
    } wr_state_t;

    wr_state_t state;
    // High for the cycle after an ack, strobe stays low
    logic      gap_q;
    mb_coord_t col_q;
    mb_edges_t edges_q;
    logic      take;

    assign store_ready = (state == idle);
    assign take        = store_valid && store_ready;

    // ------------------------------------------------------------------------
    // Write sequence
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
            gap_q <= 1'b0;
            col_q <= '0;
        end else begin
            gap_q <= bus_in.ack;
            case (state)
                idle: begin
                    if (take) begin
                        state <= wr_luma;
                        col_q <= store_col;
                    end
                end
                wr_luma: begin
                    if (bus_in.ack) begin
                        state <= wr_chroma;
                    end
                end
                wr_chroma: begin
                    if (bus_in.ack) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // Bottom rows for the line buffer, right columns for the next macroblock
    always_ff @(posedge clk) begin
        if (take) begin
            edges_q <= store_edges;
        end
    end

    assign left_edges = edges_q;

    always_comb begin
        bus_out.cyc = (state != idle) && !gap_q;
        bus_out.stb = (state != idle) && !gap_q;
        bus_out.we  = 1'b1;
        bus_out.adr = {col_q[`INTRA_LB_AW-2:0], state == wr_chroma};
        if (state == wr_chroma) begin
            bus_out.dat = {edges_q.bot_v, edges_q.bot_u};
        end else begin
            bus_out.dat = edges_q.bot_y;
        end
    end

endmodule

`default_nettype wire

/* rtl/intra_boundary_top.sv */
`timescale 1ns/1ps
`default_nettype none

module intra_boundary_top (
    input  logic                 clk,
    input  logic                 rst_n,
    // Store channel
    input  logic                 store_valid,
    output logic                 store_ready,
    input  pixel_pkg::mb_edges_t store_edges,
    // Fetch channel
    input  logic                 fetch_valid,
    output logic                 fetch_ready,
    input  mb_geom_pkg::mb_req_t fetch_req,
    // Neighbor output
    output logic                 nbr_valid,
    output pixel_pkg::nbr_set_t  nbr
);
    import mb_geom_pkg::*;
    import pixel_pkg::*;

    mb_edges_t left_edges;
    mb_coord_t cur_col;
    wb_m2s_t   wr_m2s;
    wb_s2m_t   wr_s2m;
    wb_m2s_t   fe_m2s;
    wb_s2m_t   fe_s2m;
    wb_m2s_t   ram_m2s;
    wb_s2m_t   ram_s2m;

    // Master 0
    boundary_writer writer_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .store_valid (store_valid),
        .store_ready (store_ready),
        .store_edges (store_edges),
        .store_col   (cur_col),
        .left_edges  (left_edges),
        .bus_out     (wr_m2s),
        .bus_in      (wr_s2m)
    );

    // Master 1
    neighbor_fetch fetch_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .fetch_req   (fetch_req),
        .left_edges  (left_edges),
        .cur_col     (cur_col),
        .nbr_valid   (nbr_valid),
        .nbr         (nbr),
        .bus_out     (fe_m2s),
        .bus_in      (fe_s2m)
    );

    wb_arbiter arb_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .m0_in  (wr_m2s),
        .m1_in  (fe_m2s),
        .m0_out (wr_s2m),
        .m1_out (fe_s2m),
        .s_out  (ram_m2s),
        .s_in   (ram_s2m)
    );

    line_buffer_ram ram_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .bus_in  (ram_m2s),
        .bus_out (ram_s2m)
    );

endmodule

`default_nettype wire

/* rtl/intra_config.svh */
`ifndef INTRA_CONFIG_SVH
`define INTRA_CONFIG_SVH

// ------------------------------------------------------------------------
// Picture size limit
// ------------------------------------------------------------------------

// Widest picture, in macroblocks
`define INTRA_MAX_MB_COLS 120

// Two words per column, luma then chroma
`define INTRA_LB_AW 8

// ------------------------------------------------------------------------
// Substitute samples for missing neighbors
// ------------------------------------------------------------------------

`define INTRA_FILL_TOP 8'd127
`define INTRA_FILL_LEFT 8'd129

`endif

/* rtl/line_buffer_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "intra_config.svh"

module line_buffer_ram (
    input  logic               clk,
    input  logic               rst_n,
    input  pixel_pkg::wb_m2s_t bus_in,
    output pixel_pkg::wb_s2m_t bus_out
);
    import pixel_pkg::*;

    localparam int unsigned depth = 2 * `INTRA_MAX_MB_COLS;

    lb_word_t mem [depth];
    lb_word_t rd_q;
    logic     ack_q;
    logic     access;

    // A strobe still high in its ack cycle is the same access
    assign access = bus_in.cyc && bus_in.stb && !ack_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    // Read data comes back with the ack, old contents on a write
    always_ff @(posedge clk) begin
        if (access) begin
            if (bus_in.we) begin
                mem[bus_in.adr] <= bus_in.dat;
            end
            rd_q <= mem[bus_in.adr];
        end
    end

    assign bus_out = '{ack: ack_q, dat: rd_q};

    stb_within_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        bus_in.stb |-> bus_in.cyc)
        else $error("line_buffer_ram: stb raised without cyc");

endmodule

`default_nettype wire

/* rtl/mb_geom_pkg.sv */
`default_nettype none

package mb_geom_pkg;

    // Macroblock column or row index
    typedef logic [7:0] mb_coord_t;

    // Fetch request for one macroblock
    typedef struct packed {
        mb_coord_t mb_x;
        mb_coord_t mb_y;
        // Picture width in macroblocks
        mb_coord_t pic_mb_width;
    } mb_req_t;

endpackage

`default_nettype wire

/* rtl/neighbor_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "intra_config.svh"

module neighbor_fetch (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   fetch_valid,
    output logic                   fetch_ready,
    input  mb_geom_pkg::mb_req_t   fetch_req,
    input  pixel_pkg::mb_edges_t   left_edges,
    output mb_geom_pkg::mb_coord_t cur_col,
    output logic                   nbr_valid,
    output pixel_pkg::nbr_set_t    nbr,
    output pixel_pkg::wb_m2s_t     bus_out,
    input  pixel_pkg::wb_s2m_t     bus_in
);
    import mb_geom_pkg::*;
    import pixel_pkg::*;

    typedef enum logic [2:0] {
        idle,
        rd_top,
        rd_chroma,
        rd_top_right,
        done
    } fetch_state_t;

    fetch_state_t  state;
    logic          gap_q;
    logic          take;
    mb_coord_t     col_q;
    mb_coord_t     rd_col;
    logic          left_av;
    logic          top_av;
    logic          tr_av;
    logic          left_av_q;
    logic          top_av_q;
    logic          tr_av_q;
    luma_row_t     top_y_q;
    chroma_row_t   top_u_q;
    chroma_row_t   top_v_q;
    sample_t [3:0] tr_q;
    sample_t       tl_y_q;
    sample_t       tl_u_q;
    sample_t       tl_v_q;
    nbr_set_t      nbr_d;
    nbr_set_t      nbr_q;
    logic          nbr_valid_q;

    assign fetch_ready = (state == idle);
    assign take        = fetch_valid && fetch_ready;

    // Availability of the requested macroblock
    assign left_av = (fetch_req.mb_x != '0);
    assign top_av  = (fetch_req.mb_y != '0);
    assign tr_av   = top_av &&
                     ({1'b0, fetch_req.mb_x} + 9'd1 < {1'b0, fetch_req.pic_mb_width});

    // ------------------------------------------------------------------------
    // Read sequence, reads that would be filled are skipped
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= idle;
            gap_q       <= 1'b0;
            col_q       <= '0;
            left_av_q   <= 1'b0;
            top_av_q    <= 1'b0;
            tr_av_q     <= 1'b0;
            nbr_valid_q <= 1'b0;
        end else begin
            gap_q       <= bus_in.ack;
            nbr_valid_q <= (state == done);
            case (state)
                idle: begin
                    if (take) begin
                        col_q     <= fetch_req.mb_x;
                        left_av_q <= left_av;
                        top_av_q  <= top_av;
                        tr_av_q   <= tr_av;
                        state     <= top_av ? rd_top : done;
                    end
                end
                rd_top: begin
                    if (bus_in.ack) begin
                        state <= rd_chroma;
                    end
                end
                rd_chroma: begin
                    if (bus_in.ack) begin
                        state <= tr_av_q ? rd_top_right : done;
                    end
                end
                rd_top_right: begin
                    if (bus_in.ack) begin
                        state <= done;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        // Top words of the previous macroblock give the corner samples
        if (take) begin
            tl_y_q <= top_y_q[15];
            tl_u_q <= top_u_q[7];
            tl_v_q <= top_v_q[7];
        end
        if (bus_in.ack) begin
            case (state)
                rd_top: top_y_q <= bus_in.dat;
                rd_chroma: begin
                    top_u_q <= bus_in.dat[63:0];
                    top_v_q <= bus_in.dat[127:64];
                end
                rd_top_right: tr_q <= bus_in.dat[31:0];
                default: ;
            endcase
        end
        if (state == done) begin
            nbr_q <= nbr_d;
        end
    end

    // ------------------------------------------------------------------------
    // Neighbor assembly with fill
    // ------------------------------------------------------------------------

    always_comb begin
        if (top_av_q) begin
            nbr_d.top_y       = top_y_q;
            nbr_d.top_u       = top_u_q;
            nbr_d.top_v       = top_v_q;
            // Past the right picture edge, repeat the last top sample
            nbr_d.top_right_y = tr_av_q ? tr_q : {4{top_y_q[15]}};
        end else begin
            nbr_d.top_y       = {16{`INTRA_FILL_TOP}};
            nbr_d.top_u       = {8{`INTRA_FILL_TOP}};
            nbr_d.top_v       = {8{`INTRA_FILL_TOP}};
            nbr_d.top_right_y = {4{`INTRA_FILL_TOP}};
        end
        if (left_av_q) begin
            nbr_d.left_y     = left_edges.right_y;
            nbr_d.left_u     = left_edges.right_u;
            nbr_d.left_v     = left_edges.right_v;
            nbr_d.top_left_y = top_av_q ? tl_y_q : `INTRA_FILL_TOP;
            nbr_d.top_left_u = top_av_q ? tl_u_q : `INTRA_FILL_TOP;
            nbr_d.top_left_v = top_av_q ? tl_v_q : `INTRA_FILL_TOP;
        end else begin
            nbr_d.left_y     = {16{`INTRA_FILL_LEFT}};
            nbr_d.left_u     = {8{`INTRA_FILL_LEFT}};
            nbr_d.left_v     = {8{`INTRA_FILL_LEFT}};
            nbr_d.top_left_y = `INTRA_FILL_LEFT;
            nbr_d.top_left_u = `INTRA_FILL_LEFT;
            nbr_d.top_left_v = `INTRA_FILL_LEFT;
        end
    end

    // Top-right word lives one column further on
    assign rd_col = (state == rd_top_right) ? col_q + 8'd1 : col_q;

    always_comb begin
        bus_out.cyc = (state inside {rd_top, rd_chroma, rd_top_right}) && !gap_q;
        bus_out.stb = (state inside {rd_top, rd_chroma, rd_top_right}) && !gap_q;
        bus_out.we  = 1'b0;
        bus_out.adr = {rd_col[`INTRA_LB_AW-2:0], state == rd_chroma};
        bus_out.dat = '0;
    end

    assign cur_col   = col_q;
    assign nbr_valid = nbr_valid_q;
    assign nbr       = nbr_q;

    nbr_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        nbr_valid |=> !nbr_valid)
        else $error("neighbor_fetch: nbr_valid held for two cycles");

endmodule

`default_nettype wire

/* rtl/pixel_pkg.sv */
`default_nettype none

`include "intra_config.svh"

package pixel_pkg;

    // ------------------------------------------------------------------------
    // Samples and edges
    // ------------------------------------------------------------------------

    typedef logic [7:0] sample_t;

    // Sample 0 sits in the low bits, rows and columns alike
    typedef sample_t [15:0] luma_row_t;
    typedef sample_t [7:0] chroma_row_t;

    // Edges of a finished macroblock
    typedef struct packed {
        luma_row_t   bot_y;
        luma_row_t   right_y;
        chroma_row_t bot_u;
        chroma_row_t right_u;
        chroma_row_t bot_v;
        chroma_row_t right_v;
    } mb_edges_t;

    // Everything intra prediction needs around one macroblock
    typedef struct packed {
        luma_row_t     top_y;
        sample_t [3:0] top_right_y;
        chroma_row_t   top_u;
        chroma_row_t   top_v;
        luma_row_t     left_y;
        chroma_row_t   left_u;
        chroma_row_t   left_v;
        sample_t       top_left_y;
        sample_t       top_left_u;
        sample_t       top_left_v;
    } nbr_set_t;

    // ------------------------------------------------------------------------
    // Line buffer bus
    // ------------------------------------------------------------------------

    // Even address luma row, odd address chroma word with u in the low half
    typedef logic [`INTRA_LB_AW-1:0] lb_addr_t;
    typedef logic [127:0] lb_word_t;

    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        lb_addr_t adr;
        lb_word_t dat;
    } wb_m2s_t;

    typedef struct packed {
        logic     ack;
        lb_word_t dat;
    } wb_s2m_t;

endpackage

`default_nettype wire

/* rtl/wb_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter (
    input  logic               clk,
    input  logic               rst_n,
    input  pixel_pkg::wb_m2s_t m0_in,
    input  pixel_pkg::wb_m2s_t m1_in,
    output pixel_pkg::wb_s2m_t m0_out,
    output pixel_pkg::wb_s2m_t m1_out,
    output pixel_pkg::wb_m2s_t s_out,
    input  pixel_pkg::wb_s2m_t s_in
);
    // Bus owned in the previous cycle
    logic lock_q;
    // Master of the most recent grant
    logic last_q;
    logic owner_cyc;
    logic hold;
    logic pick;
    logic gnt;
    logic gnt_cyc;

    // ------------------------------------------------------------------------
    // Grant
    // ------------------------------------------------------------------------

    // Current owner keeps the bus until it drops cyc
    assign owner_cyc = last_q ? m1_in.cyc : m0_in.cyc;
    assign hold      = lock_q && owner_cyc;

    // Tie goes to the master that waited
    assign pick    = (m0_in.cyc && m1_in.cyc) ? !last_q : m1_in.cyc;
    assign gnt     = hold ? last_q : pick;
    assign gnt_cyc = gnt ? m1_in.cyc : m0_in.cyc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lock_q <= 1'b0;
            last_q <= 1'b1;
        end else begin
            lock_q <= gnt_cyc;
            if (gnt_cyc) begin
                last_q <= gnt;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Routing
    // ------------------------------------------------------------------------

    assign s_out  = gnt ? m1_in : m0_in;
    assign m0_out = '{ack: s_in.ack && !gnt, dat: s_in.dat};
    assign m1_out = '{ack: s_in.ack && gnt, dat: s_in.dat};

    // An ack answers the strobe of the master granted one cycle earlier
    ack_to_owner: assert property (@(posedge clk) disable iff (!rst_n)
        s_in.ack |-> $past(gnt_cyc) && (gnt == $past(gnt)))
        else $error("wb_arbiter: ack routed away from its requester");

endmodule

`default_nettype wire

/* tb/clk_rst_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clk_rst_gen (
    output logic clk,
    output logic rst_n
);
    localparam time half_period = 5ns;
    localparam int  reset_cycles = 8;

    // 10 ns clock
    initial begin
        clk = 1'b0;
        forever begin
            #half_period clk = ~clk;
        end
    end

    // Release just after an edge, like the other inputs
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* tb/intra_boundary_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module intra_boundary_tb;
    import mb_geom_pkg::*;
    import pixel_pkg::*;

    localparam int num_pics       = 8;
    localparam int max_width      = 6;
    localparam int max_mbs        = num_pics * max_width * 3;
    localparam int timeout_cycles = max_mbs * 20 + 200;
    localparam logic [7:0] fill_top  = 8'd127;
    localparam logic [7:0] fill_left = 8'd129;

    logic      clk;
    logic      rst_n;
    logic      store_valid;
    logic      store_ready;
    mb_edges_t store_edges;
    logic      fetch_valid;
    logic      fetch_ready;
    mb_req_t   fetch_req;
    logic      nbr_valid;
    nbr_set_t  nbr;

    logic [15:0] lfsr_state;
    int unsigned err_count;
    int unsigned check_count;
    int unsigned fetch_count;
    int unsigned pulse_count;

    // Model of the line buffer and the boundary registers
    luma_row_t   lb_y [max_width];
    chroma_row_t lb_u [max_width];
    chroma_row_t lb_v [max_width];
    luma_row_t   prev_top_y;
    chroma_row_t prev_top_u;
    chroma_row_t prev_top_v;
    mb_edges_t   prev_edges;

    clk_rst_gen clk_rst_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    intra_boundary_top intra_boundary_top_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .store_valid (store_valid),
        .store_ready (store_ready),
        .store_edges (store_edges),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .fetch_req   (fetch_req),
        .nbr_valid   (nbr_valid),
        .nbr         (nbr)
    );

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------

    // Fibonacci LFSR, taps 16 14 13 11, one step per bit
    function automatic logic [127:0] rand_bits(input int n);
        logic [127:0] v;
        logic         fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            v = {v[126:0], fb};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            $display("error %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic run_fetch(input mb_coord_t x, input mb_coord_t y, input mb_coord_t w);
        logic accepted;
        fetch_req   = '{mb_x: x, mb_y: y, pic_mb_width: w};
        fetch_valid = 1'b1;
        do begin
            accepted = fetch_ready;
            next_cycle();
        end while (!accepted);
        fetch_valid = 1'b0;
        fetch_count++;
        while (!nbr_valid) begin
            next_cycle();
        end
    endtask

    task automatic run_store(input mb_edges_t edges);
        logic accepted;
        store_edges = edges;
        store_valid = 1'b1;
        do begin
            accepted = store_ready;
            next_cycle();
        end while (!accepted);
        store_valid = 1'b0;
    endtask

    task automatic wait_store_idle();
        while (!store_ready) begin
            next_cycle();
        end
    endtask

    // Neighbor set by the availability and fill rules
    function automatic nbr_set_t expected_nbr(input mb_coord_t x, input mb_coord_t y,
                                              input mb_coord_t w);
        nbr_set_t e;
        logic     left_av;
        logic     top_av;
        logic     tr_av;
        left_av = (x > 0);
        top_av  = (y > 0);
        tr_av   = top_av && (x + 1 < w);
        if (top_av) begin
            e.top_y       = lb_y[x];
            e.top_u       = lb_u[x];
            e.top_v       = lb_v[x];
            e.top_right_y = tr_av ? lb_y[x + 1][3:0] : {4{lb_y[x][15]}};
        end else begin
            e.top_y       = {16{fill_top}};
            e.top_u       = {8{fill_top}};
            e.top_v       = {8{fill_top}};
            e.top_right_y = {4{fill_top}};
        end
        if (!left_av) begin
            e.left_y     = {16{fill_left}};
            e.left_u     = {8{fill_left}};
            e.left_v     = {8{fill_left}};
            e.top_left_y = fill_left;
            e.top_left_u = fill_left;
            e.top_left_v = fill_left;
        end else begin
            e.left_y     = prev_edges.right_y;
            e.left_u     = prev_edges.right_u;
            e.left_v     = prev_edges.right_v;
            e.top_left_y = top_av ? prev_top_y[15] : fill_top;
            e.top_left_u = top_av ? prev_top_u[7] : fill_top;
            e.top_left_v = top_av ? prev_top_v[7] : fill_top;
        end
        return e;
    endfunction

    task automatic compare_nbr(input string tag, input nbr_set_t e, input nbr_set_t a);
        check_value({tag, " top_y"}, e.top_y, a.top_y);
        check_value({tag, " top_right_y"}, e.top_right_y, a.top_right_y);
        check_value({tag, " top_u"}, e.top_u, a.top_u);
        check_value({tag, " top_v"}, e.top_v, a.top_v);
        check_value({tag, " left_y"}, e.left_y, a.left_y);
        check_value({tag, " left_u"}, e.left_u, a.left_u);
        check_value({tag, " left_v"}, e.left_v, a.left_v);
        check_value({tag, " top_left_y"}, e.top_left_y, a.top_left_y);
        check_value({tag, " top_left_u"}, e.top_left_u, a.top_left_u);
        check_value({tag, " top_left_v"}, e.top_left_v, a.top_left_v);
    endtask

    // ------------------------------------------------------------------------
    // Monitor and watchdog
    // ------------------------------------------------------------------------

    // Mid-cycle sample, nbr_valid is stable here
    always @(negedge clk) begin
        if (rst_n && nbr_valid) begin
            pulse_count++;
        end
    end

    initial begin
        repeat (timeout_cycles + 8) @(posedge clk);
        $display("watchdog: run still busy after %0d cycles, a handshake never completed",
                 timeout_cycles);
        $display("STATUS: FAIL");
        $finish;
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------

    initial begin
        mb_coord_t w;
        mb_coord_t h;
        mb_edges_t edges;
        nbr_set_t  exp_nbr;
        string     tag;
        store_valid = 1'b0;
        store_edges = '0;
        fetch_valid = 1'b0;
        fetch_req   = '0;
        lfsr_state  = 16'd28077;
        err_count   = 0;
        check_count = 0;
        fetch_count = 0;
        pulse_count = 0;

        @(posedge rst_n);
        check_value("reset store_ready", 1'b1, store_ready);
        check_value("reset fetch_ready", 1'b1, fetch_ready);
        check_value("reset nbr_valid", 1'b0, nbr_valid);

        for (int pic = 0; pic < num_pics; pic++) begin
            // First picture is one column wide, so every row hits the right edge
            w = (pic == 0) ? 8'd1 : 8'(1 + rand_bits(8) % max_width);
            h = 8'(2 + rand_bits(1));
            for (int y = 0; y < h; y++) begin
                for (int x = 0; x < w; x++) begin
                    repeat (int'(rand_bits(1))) next_cycle();
                    run_fetch(x, y, w);
                    exp_nbr = expected_nbr(x, y, w);
                    tag = $sformatf("pic%0d mb(%0d,%0d)", pic, x, y);
                    compare_nbr(tag, exp_nbr, nbr);
                    if (y > 0) begin
                        prev_top_y = lb_y[x];
                        prev_top_u = lb_u[x];
                        prev_top_v = lb_v[x];
                    end
                    edges[127:0]   = rand_bits(128);
                    edges[255:128] = rand_bits(128);
                    edges[383:256] = rand_bits(128);
                    edges[511:384] = rand_bits(128);
                    run_store(edges);
                    lb_y[x]    = edges.bot_y;
                    lb_u[x]    = edges.bot_u;
                    lb_v[x]    = edges.bot_v;
                    prev_edges = edges;
                    // Otherwise the next fetch overlaps this store
                    if (rand_bits(1) == 0) begin
                        wait_store_idle();
                    end
                end
            end
        end
        wait_store_idle();
        repeat (2) next_cycle();
        check_value("nbr_valid pulses", fetch_count, pulse_count);

        $display("checks %0d, errors %0d, fetches %0d", check_count, err_count, fetch_count);
        if (err_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
